//--- verilog/quiz_pkg.sv
package quiz_pkg;

    // practice modes, numbered 2 to 5 on the display
    typedef enum logic [1:0] {
        mode_signed  = 2'd0,
        mode_shift   = 2'd1,
        mode_bitwise = 2'd2,
        mode_logic   = 2'd3
    } mode_t;

    // operator slot, meaning depends on the mode
    typedef enum logic [1:0] {
        op_1 = 2'd0,
        op_2 = 2'd1,
        op_3 = 2'd2,
        op_4 = 2'd3
    } op_t;

    typedef logic [7:0] byte_t;    // operand and answer word
    typedef logic [7:0] seg_t;     // segments a..g in bits 7..1, dp in bit 0
    typedef logic [6:0] count_t;   // holds 0..99

    localparam int num_modes       = 4;
    localparam int num_digits      = 8;
    localparam int count_max       = 99;  // attempts stop here
    localparam int mode_label_base = 2;   // label shown for mode_signed

    // digit 1 sits in the top byte
    typedef seg_t [num_digits-1:0] seg_row_t;

    localparam seg_t seg_digit [0:9] = '{
        8'b1111_1100,  // 0
        8'b0110_0000,  // 1
        8'b1101_1010,  // 2
        8'b1111_0010,  // 3
        8'b0110_0110,  // 4
        8'b1011_0110,  // 5
        8'b1011_1110,  // 6
        8'b1110_0000,  // 7
        8'b1111_1110,  // 8
        8'b1111_0110   // 9
    };

    localparam seg_t seg_blank = 8'b0000_0000;
    localparam seg_t seg_minus = 8'b0000_0010;  // segment g only

endpackage

//--- verilog/quiz_item_if.sv
`timescale 1ns/10ps

// one item per cycle with valid high, no ready
interface quiz_item_if;

    logic            valid;
    quiz_pkg::mode_t mode;
    quiz_pkg::byte_t expected;  // correct answer from the calc stage
    quiz_pkg::byte_t given;     // learner's answer, passed through

    modport source (
        output valid,
        output mode,
        output expected,
        output given
    );

    modport sink (
        input valid,
        input mode,
        input expected,
        input given
    );

endinterface

//--- verilog/answer_calc.sv
`timescale 1ns/10ps

module answer_calc (
    input  logic              clk,
    input  logic              reset,
    input  logic              item_valid,
    input  quiz_pkg::mode_t   item_mode,
    input  quiz_pkg::op_t     item_op,
    input  quiz_pkg::byte_t   item_a,
    input  quiz_pkg::byte_t   item_b,
    input  quiz_pkg::byte_t   item_given,
    quiz_item_if.source       item
);

    quiz_pkg::byte_t expected;
    logic            a_true;
    logic            b_true;

    assign a_true = |item_a;  // non-zero counts as true
    assign b_true = |item_b;

    always_comb begin
        expected = '0;  // unused op slots answer 0
        case (item_mode)
            quiz_pkg::mode_signed: begin
                case (item_op)
                    quiz_pkg::op_1: expected = item_a + item_b;  // wraps mod 256
                    quiz_pkg::op_2: expected = item_a - item_b;
                    default:        expected = '0;
                endcase
            end
            quiz_pkg::mode_shift: begin
                // full 8-bit amount, 8 and up shifts everything out
                case (item_op)
                    quiz_pkg::op_1: expected = item_a <<< item_b;
                    quiz_pkg::op_2: expected = $signed(item_a) >>> item_b;  // sign fill
                    quiz_pkg::op_3: expected = item_a << item_b;
                    quiz_pkg::op_4: expected = item_a >> item_b;
                endcase
            end
            quiz_pkg::mode_bitwise: begin
                case (item_op)
                    quiz_pkg::op_1: expected = item_a & item_b;
                    quiz_pkg::op_2: expected = item_a | item_b;
                    quiz_pkg::op_3: expected = ~item_a;
                    quiz_pkg::op_4: expected = item_a ^ item_b;
                endcase
            end
            quiz_pkg::mode_logic: begin
                case (item_op)
                    quiz_pkg::op_1: expected = {8{a_true && b_true}};
                    quiz_pkg::op_2: expected = {8{a_true || b_true}};
                    quiz_pkg::op_3: expected = {8{!a_true}};
                    quiz_pkg::op_4: expected = {8{a_true ^ b_true}};
                endcase
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            item.valid <= 1'b0;
        end else begin
            item.valid <= item_valid;
        end
        if (item_valid) begin  // payload only moves with an item
            item.mode     <= item_mode;
            item.expected <= expected;
            item.given    <= item_given;
        end
    end

endmodule

//--- verilog/answer_grade.sv
`timescale 1ns/10ps

module answer_grade (
    input  logic             clk,
    input  logic             reset,
    quiz_item_if.sink        item,
    output logic             graded_valid,
    output quiz_pkg::mode_t  graded_mode,
    output logic             graded_pass
);

    logic match;

    // single-byte answers, so one compare covers every mode
    assign match = (item.given == item.expected);

    always_ff @(posedge clk) begin
        if (reset) begin
            graded_valid <= 1'b0;
            graded_pass  <= 1'b0;
        end else begin
            graded_valid <= item.valid;  // one pulse per item
            if (item.valid) begin
                graded_pass <= match;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (item.valid) begin
            graded_mode <= item.mode;
        end
    end

endmodule

//--- verilog/score_tracker.sv
`timescale 1ns/10ps

module score_tracker (
    input  logic             clk,
    input  logic             reset,
    input  logic             graded_valid,
    input  quiz_pkg::mode_t  graded_mode,
    input  logic             graded_pass,
    output quiz_pkg::count_t attempts [quiz_pkg::num_modes],
    output quiz_pkg::count_t corrects [quiz_pkg::num_modes]
);

    logic room;

    // a mode that has hit the limit freezes both counts
    assign room = attempts[graded_mode] < quiz_pkg::count_t'(quiz_pkg::count_max);

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int m = 0; m < quiz_pkg::num_modes; m++) begin
                attempts[m] <= '0;
                corrects[m] <= '0;
            end
        end else if (graded_valid && room) begin
            attempts[graded_mode] <= attempts[graded_mode] + 1'b1;
            if (graded_pass) begin
                corrects[graded_mode] <= corrects[graded_mode] + 1'b1;  // never passes attempts
            end
        end
    end

endmodule

//--- verilog/stats_display.sv
`timescale 1ns/10ps

module stats_display (
    input  logic               clk,
    input  logic               reset,
    input  quiz_pkg::mode_t    view_mode,
    input  quiz_pkg::count_t   attempts [quiz_pkg::num_modes],
    input  quiz_pkg::count_t   corrects [quiz_pkg::num_modes],
    output quiz_pkg::seg_row_t seg_row
);

    // decimal digit to segments, anything above 9 goes blank
    function automatic quiz_pkg::seg_t digit_seg(input logic [3:0] d);
        quiz_pkg::seg_t code;
        code = quiz_pkg::seg_blank;
        if (d <= 4'd9) begin
            code = quiz_pkg::seg_digit[d];
        end
        return code;
    endfunction

    quiz_pkg::count_t att;
    quiz_pkg::count_t cor;
    logic [6:0]       divisor;
    logic [13:0]      scaled;
    logic [6:0]       pct;
    logic [3:0]       label;
    quiz_pkg::seg_t   label_seg;
    quiz_pkg::seg_t   att_tens;
    quiz_pkg::seg_t   att_ones;
    quiz_pkg::seg_row_t row_next;

    assign att     = attempts[view_mode];
    assign cor     = corrects[view_mode];
    assign divisor = (att == '0) ? 7'd1 : att;  // keeps the divider defined at zero
    assign scaled  = 14'(cor) * 14'd100;
    assign pct     = 7'(scaled / 14'(divisor));  // truncated, 0..100

    assign label     = 4'(view_mode) + 4'(quiz_pkg::mode_label_base);
    assign label_seg = digit_seg(label);
    assign att_tens  = digit_seg(4'(att / 7'd10));
    assign att_ones  = digit_seg(4'(att % 7'd10));

    always_comb begin
        if (att == '0) begin
            row_next = {label_seg, quiz_pkg::seg_blank, att_tens, att_ones,
                        quiz_pkg::seg_blank,
                        quiz_pkg::seg_minus, quiz_pkg::seg_minus, quiz_pkg::seg_minus};
        end else if (pct == 7'd100) begin
            row_next = {label_seg, quiz_pkg::seg_blank, att_tens, att_ones,
                        quiz_pkg::seg_blank,
                        quiz_pkg::seg_digit[1], quiz_pkg::seg_digit[0],
                        quiz_pkg::seg_digit[0]};
        end else begin
            row_next = {label_seg, quiz_pkg::seg_blank, att_tens, att_ones,
                        quiz_pkg::seg_blank, quiz_pkg::seg_blank,
                        digit_seg(4'(pct / 7'd10)), digit_seg(4'(pct % 7'd10))};
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            // counts read as zero while in reset
            seg_row <= {label_seg, quiz_pkg::seg_blank,
                        quiz_pkg::seg_digit[0], quiz_pkg::seg_digit[0],
                        quiz_pkg::seg_blank,
                        quiz_pkg::seg_minus, quiz_pkg::seg_minus, quiz_pkg::seg_minus};
        end else begin
            seg_row <= row_next;
        end
    end

endmodule

//--- verilog/quiz_top.sv
`timescale 1ns/10ps

module quiz_top (
    input  logic               clk,
    input  logic               reset,
    input  logic               item_valid,
    input  quiz_pkg::mode_t    item_mode,
    input  quiz_pkg::op_t      item_op,
    input  quiz_pkg::byte_t    item_a,
    input  quiz_pkg::byte_t    item_b,
    input  quiz_pkg::byte_t    item_given,
    input  quiz_pkg::mode_t    view_mode,
    output logic               result_valid,
    output logic               result_pass,
    output quiz_pkg::seg_row_t seg_row
);

    quiz_pkg::mode_t  graded_mode;
    quiz_pkg::count_t attempts [quiz_pkg::num_modes];
    quiz_pkg::count_t corrects [quiz_pkg::num_modes];

    quiz_item_if item_bus ();

    answer_calc calc_i (
        .clk        (clk),
        .reset      (reset),
        .item_valid (item_valid),
        .item_mode  (item_mode),
        .item_op    (item_op),
        .item_a     (item_a),
        .item_b     (item_b),
        .item_given (item_given),
        .item       (item_bus.source)
    );

    answer_grade grade_i (
        .clk          (clk),
        .reset        (reset),
        .item         (item_bus.sink),
        .graded_valid (result_valid),  // verdict goes straight out
        .graded_mode  (graded_mode),
        .graded_pass  (result_pass)
    );

    score_tracker score_i (
        .clk          (clk),
        .reset        (reset),
        .graded_valid (result_valid),
        .graded_mode  (graded_mode),
        .graded_pass  (result_pass),
        .attempts     (attempts),
        .corrects     (corrects)
    );

    stats_display display_i (
        .clk       (clk),
        .reset     (reset),
        .view_mode (view_mode),
        .attempts  (attempts),
        .corrects  (corrects),
        .seg_row   (seg_row)
    );

endmodule

//--- tests/quiz_tb.sv
`timescale 1ns/10ps

module quiz_tb;

    localparam int num_rows        = 28;
    localparam int num_flood       = 105;  // more than count_max items of one mode
    localparam int watchdog_cycles = (num_rows + num_flood) * 3 + 200;

    // {mode, op, a, b}
    localparam logic [19:0] stim_table [num_rows] = '{
        {2'd0, 2'd0, 8'h05, 8'h03}, {2'd0, 2'd0, 8'h7F, 8'h01},  // signed overflow
        {2'd0, 2'd1, 8'h80, 8'h01}, {2'd0, 2'd1, 8'h10, 8'h20},
        {2'd0, 2'd2, 8'h12, 8'h34}, {2'd0, 2'd3, 8'hAA, 8'h55},
        {2'd1, 2'd0, 8'h81, 8'd0},  {2'd1, 2'd0, 8'h81, 8'd7},
        {2'd1, 2'd1, 8'h90, 8'd7},  {2'd1, 2'd1, 8'h90, 8'd8},
        {2'd1, 2'd1, 8'h90, 8'd200}, {2'd1, 2'd1, 8'h70, 8'd200},
        {2'd1, 2'd2, 8'h0F, 8'd8},  {2'd1, 2'd2, 8'h0F, 8'd3},
        {2'd1, 2'd3, 8'hF0, 8'd200}, {2'd1, 2'd3, 8'hF0, 8'd4},
        {2'd2, 2'd0, 8'hC3, 8'h5A}, {2'd2, 2'd1, 8'hC3, 8'h5A},
        {2'd2, 2'd2, 8'hC3, 8'h00}, {2'd2, 2'd3, 8'hC3, 8'h5A},
        {2'd3, 2'd0, 8'h00, 8'h05}, {2'd3, 2'd0, 8'h03, 8'h05},
        {2'd3, 2'd1, 8'h00, 8'h00}, {2'd3, 2'd1, 8'h00, 8'h09},
        {2'd3, 2'd2, 8'h00, 8'h00}, {2'd3, 2'd2, 8'h40, 8'h00},
        {2'd3, 2'd3, 8'h01, 8'h02}, {2'd3, 2'd3, 8'h00, 8'h02}
    };

    logic               clk;
    logic               reset;
    logic               item_valid;
    quiz_pkg::mode_t    item_mode;
    quiz_pkg::op_t      item_op;
    quiz_pkg::byte_t    item_a;
    quiz_pkg::byte_t    item_b;
    quiz_pkg::byte_t    item_given;
    quiz_pkg::mode_t    view_mode;
    logic               result_valid;
    logic               result_pass;
    quiz_pkg::seg_row_t seg_row;

    logic [31:0] lfsr_state;
    int          cycle;
    int          errors;
    int          checks;
    int          due_q [$];   // cycle at which each verdict should show
    logic        pass_q [$];
    int          model_att [4];
    int          model_cor [4];

    quiz_top dut_i (
        .clk          (clk),
        .reset        (reset),
        .item_valid   (item_valid),
        .item_mode    (item_mode),
        .item_op      (item_op),
        .item_a       (item_a),
        .item_b       (item_b),
        .item_given   (item_given),
        .view_mode    (view_mode),
        .result_valid (result_valid),
        .result_pass  (result_pass),
        .seg_row      (seg_row)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    initial begin
        repeat (watchdog_cycles) @(posedge clk);
        $display("watchdog expired after %0d clock periods, run stopped", watchdog_cycles);
        $display("TESTS FAILED");
        $finish;
    end

    // galois form, x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    task automatic take_bit(output logic b);
        b = lfsr_state[0];
        lfsr_state = lfsr_next(lfsr_state);
    endtask

    task automatic take_bits(input int n, output logic [7:0] v);
        logic b;
        v = 8'h00;
        for (int i = 0; i < n; i++) begin
            take_bit(b);
            v = {v[6:0], b};
        end
    endtask

    function automatic logic [7:0] expected_answer(input int m, input int op,
                                                   input logic [7:0] a, input logic [7:0] b);
        logic [7:0] r;
        logic       at;
        logic       bt;
        at = (a != 8'h00);
        bt = (b != 8'h00);
        r = 8'h00;
        if (m == 0) begin
            if (op == 0) r = a + b;
            else if (op == 1) r = a - b;
        end else if (m == 1) begin
            if (b > 8'd7) r = (op == 1 && a[7]) ? 8'hFF : 8'h00;  // all shifted out
            else if (op == 1) r = $signed(a) >>> b[2:0];
            else if (op == 3) r = a >> b[2:0];
            else r = a << b[2:0];
        end else if (m == 2) begin
            if (op == 0) r = a & b;
            else if (op == 1) r = a | b;
            else if (op == 2) r = ~a;
            else r = a ^ b;
        end else begin
            if (op == 0) r = {8{at & bt}};
            else if (op == 1) r = {8{at | bt}};
            else if (op == 2) r = {8{~at}};
            else r = {8{at ^ bt}};
        end
        return r;
    endfunction

    function automatic quiz_pkg::seg_row_t expected_row(input int m, input int att, input int cor);
        quiz_pkg::seg_row_t row;
        int                 pct;
        row[7] = quiz_pkg::seg_digit[m + quiz_pkg::mode_label_base];
        row[6] = quiz_pkg::seg_blank;
        row[5] = quiz_pkg::seg_digit[att / 10];
        row[4] = quiz_pkg::seg_digit[att % 10];
        row[3] = quiz_pkg::seg_blank;
        if (att == 0) begin
            row[2:0] = {3{quiz_pkg::seg_minus}};
        end else begin
            pct = cor * 100 / att;
            row[2] = (pct == 100) ? quiz_pkg::seg_digit[1] : quiz_pkg::seg_blank;
            row[1] = quiz_pkg::seg_digit[(pct / 10) % 10];
            row[0] = quiz_pkg::seg_digit[pct % 10];
        end
        return row;
    endfunction

    // one falling edge, verdict checked against what is due this cycle
    task automatic tick();
        @(negedge clk);
        cycle++;
        if (result_valid === 1'b1) begin
            if (due_q.size() == 0 || due_q[0] != cycle) begin
                $display("result_valid pulsed at %0t when no item was due", $time);
                errors++;
            end else begin
                checks++;
                if (result_pass !== pass_q[0]) begin
                    $display("Error %0t: result_pass is %b, expected %b",
                             $time, result_pass, pass_q[0]);
                    errors++;
                end
                void'(due_q.pop_front());
                void'(pass_q.pop_front());
            end
        end else if (due_q.size() != 0 && due_q[0] == cycle) begin
            $display("result_valid never pulsed at %0t for a due item", $time);
            errors++;
            void'(due_q.pop_front());
            void'(pass_q.pop_front());
        end
    endtask

    task automatic apply_item(input int m, input int op, input logic [7:0] a,
                              input logic [7:0] b);
        logic [7:0] answer;
        logic       keep;
        answer = expected_answer(m, op, a, b);
        take_bit(keep);  // 1 means the learner answers right
        item_valid = 1'b1;
        item_mode  = quiz_pkg::mode_t'(m);
        item_op    = quiz_pkg::op_t'(op);
        item_a     = a;
        item_b     = b;
        item_given = keep ? answer : answer ^ 8'h01;
        due_q.push_back(cycle + 2);
        pass_q.push_back(keep);
        if (model_att[m] < quiz_pkg::count_max) begin
            model_att[m]++;
            if (keep) model_cor[m]++;
        end
        tick();
    endtask

    task automatic drain();
        int waited;
        waited = 0;
        item_valid = 1'b0;
        while (due_q.size() != 0 && waited < 10) begin
            tick();
            waited++;
        end
        if (due_q.size() != 0) begin
            $display("%0d result_valid pulses never arrived", due_q.size());
            errors++;
            due_q.delete();
            pass_q.delete();
        end
        tick();  // counts settle
        tick();
    endtask

    task automatic check_view(input int m);
        quiz_pkg::seg_row_t want;
        view_mode = quiz_pkg::mode_t'(m);
        tick();
        tick();
        want = expected_row(m, model_att[m], model_cor[m]);
        checks++;
        if (seg_row !== want) begin
            $display("Error %0t: view %0d shows %h, expected %h", $time, m, seg_row, want);
            errors++;
        end
    endtask

    task automatic do_reset();
        quiz_pkg::seg_row_t want;
        reset = 1'b1;
        item_valid = 1'b0;
        repeat (10) tick();
        want = expected_row(int'(view_mode), 0, 0);  // zero-count view while in reset
        checks++;
        if (seg_row !== want) begin
            $display("Error %0t: reset view shows %h, expected %h", $time, seg_row, want);
            errors++;
        end
        if (result_pass !== 1'b0) begin
            $display("Error %0t: result_pass is %b in reset, expected 0", $time, result_pass);
            errors++;
        end
        reset = 1'b0;
        for (int m = 0; m < 4; m++) begin
            model_att[m] = 0;
            model_cor[m] = 0;
        end
    endtask

    initial begin
        logic [7:0] rop;
        logic [7:0] ra;
        logic [7:0] rb;
        reset      = 1'b1;
        item_valid = 1'b0;
        item_mode  = quiz_pkg::mode_signed;
        item_op    = quiz_pkg::op_1;
        item_a     = 8'h00;
        item_b     = 8'h00;
        item_given = 8'h00;
        view_mode  = quiz_pkg::mode_signed;
        lfsr_state = 32'd83857;
        cycle      = 0;
        errors     = 0;
        checks     = 0;
        do_reset();
        for (int m = 0; m < 4; m++) check_view(m);  // zero view everywhere

        for (int r = 0; r < num_rows; r++) begin
            apply_item(int'(stim_table[r][19:18]), int'(stim_table[r][17:16]),
                       stim_table[r][15:8], stim_table[r][7:0]);
        end
        drain();
        for (int m = 0; m < 4; m++) check_view(m);

        // flood the signed mode past the count limit
        do_reset();
        for (int r = 0; r < num_flood; r++) begin
            take_bits(2, rop);
            take_bits(8, ra);
            take_bits(8, rb);
            apply_item(0, int'(rop[1:0]), ra, rb);
        end
        drain();
        check_view(0);
        check_view(3);  // untouched mode still shows the zero view

        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

//--- files.f
verilog/quiz_pkg.sv
verilog/quiz_item_if.sv
verilog/answer_calc.sv
verilog/answer_grade.sv
verilog/score_tracker.sv
verilog/stats_display.sv
verilog/quiz_top.sv
tests/quiz_tb.sv

//--- Makefile
# Verilator build and run for the quiz core

VERILATOR ?= verilator
TOP       ?= quiz_tb
BUILD_DIR ?= build
FILE_LIST ?= files.f

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list these targets"
	@echo "  test   build with Verilator from $(FILE_LIST) and run the simulation"
	@echo "  clean  remove $(BUILD_DIR)"
	@echo "variables: VERILATOR, TOP, BUILD_DIR, FILE_LIST"

test:
	$(VERILATOR) --binary --timing -Wno-fatal -f $(FILE_LIST) \
		--top-module $(TOP) -Mdir $(BUILD_DIR) -o $(TOP)
	@out="$$(./$(BUILD_DIR)/$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "TESTS PASSED"

clean:
	rm -rf $(BUILD_DIR)
